//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sd_loader
FILELIST  = src.f
OBJDIR    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf $(OBJDIR)

//--- sim/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model (
    input  logic sdclk,
    inout  wire  sdcmd,
    output logic sddat0,
    input  logic ccs       // 1 = sdhc, block addressed
);
    localparam logic [15:0] CARD_RCA = 16'h59b4;

    logic cmd_oe;
    logic cmd_drv;
    int   blk_req;     // bumped once per accepted cmd17
    int   blk_sector;
    int   cmd0_cnt;    // a cmd0 aborts any block in flight
    int   acmd41_cnt;
    logic app_cmd;     // previous command was cmd55

    assign sdcmd = cmd_oe ? cmd_drv : 1'bz;

    // x^7 + x^3 + 1 over the 40 leading bits
    function automatic logic [6:0] crc7(input logic [39:0] bits);
        logic [6:0] r;
        logic       top;
        r = '0;
        for (int n = 39; n >= 0; n--) begin
            top = r[6] ^ bits[n];
            r   = {r[5:0], 1'b0};
            if (top)
                r = r ^ 7'b000_1001;
        end
        return r;
    endfunction

    function automatic logic [135:0] short_resp(input logic [5:0] idx, input logic [31:0] arg);
        return 136'({2'b00, idx, arg, crc7({2'b00, idx, arg}), 1'b1});
    endfunction

    // host changes sdcmd on the falling edge, so sample on the rising one
    task automatic get_cmd(output logic [47:0] c);
        do @(posedge sdclk); while (sdcmd !== 1'b0);
        c = '0;                          // start bit
        repeat (47) begin
            @(posedge sdclk);
            c = {c[46:0], sdcmd};
        end
    endtask

    task automatic put_resp(input logic [135:0] r, input int nbits);
        repeat (2) @(negedge sdclk);     // host lets go of the line first
        for (int n = nbits - 1; n >= 0; n--) begin
            cmd_drv = r[n];
            cmd_oe  = 1'b1;
            @(negedge sdclk);
        end
        cmd_oe = 1'b0;
    endtask

    task automatic send_block(input int sec, input int ref_cnt);
        logic [7:0] b;
        repeat (2) @(negedge sdclk);     // access time
        sddat0 = 1'b0;                   // start bit
        for (int n = 0; n < 4113 && cmd0_cnt == ref_cnt; n++) begin
            @(negedge sdclk);
            if (n < 4096) begin
                b      = 8'(sec * 37 + (n / 8) * 5 + 11);
                sddat0 = b[7 - n % 8];   // msb first
            end else begin
                sddat0 = (n == 4112);    // zero crc16, then end bit
            end
        end
        sddat0 = 1'b1;
    endtask

    // --------------------------------------------------
    // command side
    // --------------------------------------------------
    initial begin
        logic [47:0] c;
        logic [5:0]  idx;
        logic [31:0] arg;
        logic        was_app;
        cmd_oe     = 1'b0;
        cmd_drv    = 1'b1;
        blk_req    = 0;
        blk_sector = 0;
        cmd0_cnt   = 0;
        acmd41_cnt = 0;
        app_cmd    = 1'b0;
        forever begin
            get_cmd(c);
            idx = c[45:40];
            arg = c[39:8];
            if (c[46] && c[0] && c[7:1] == crc7(c[47:8])) begin   // bad frames get no answer
                was_app = app_cmd;
                app_cmd = (idx == 6'd55);
                case (idx)
                    6'd0: begin
                        cmd0_cnt++;
                        acmd41_cnt = 0;
                    end
                    6'd8:  put_resp(short_resp(6'd8, {20'd0, arg[11:0]}), 48);  // echo pattern
                    6'd55: put_resp(short_resp(6'd55, 32'h0000_0120), 48);
                    6'd41: if (was_app) begin
                        // busy on the first try, ready with ccs after that
                        put_resp(136'({2'b00, 6'h3f, acmd41_cnt > 0, ccs, 6'd0, 24'hff_8000,
                                       7'h7f, 1'b1}), 48);
                        acmd41_cnt++;
                    end
                    6'd2: put_resp({8'h3f, 32'h0353_4453, 32'h4331_3280, 32'h1234_5678,
                                    31'h0001_0000, 1'b1}, 136);   // cid, R2
                    6'd3: put_resp(short_resp(6'd3, {CARD_RCA, 16'h0500}), 48);
                    6'd7: if (arg[31:16] == CARD_RCA)
                        put_resp(short_resp(6'd7, 32'h0000_0700), 48);
                    6'd17: begin
                        put_resp(short_resp(6'd17, 32'h0000_0900), 48);
                        if (ccs) begin
                            blk_sector = int'(arg);
                            blk_req++;
                        end else if (arg[8:0] == 9'd0) begin   // sdv2 wants byte address
                            blk_sector = int'(arg >> 9);
                            blk_req++;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // --------------------------------------------------
    // data side
    // --------------------------------------------------
    initial begin
        int seen;
        sddat0 = 1'b1;
        seen   = 0;
        forever begin
            @(posedge sdclk);
            if (blk_req != seen) begin
                seen = blk_req;
                send_block(blk_sector, cmd0_cnt);
            end
        end
    end

endmodule

//--- sim/tb_sd_loader.sv
`timescale 1ns/1ps

module tb_sd_loader;
    import sd_loader_pkg::*;

    localparam int NUM_ROWS    = 3;
    localparam int NUM_WORDS   = LOAD_BYTES / 4;
    localparam int CLK_NS      = 20;
    localparam int SLOW_SD_NS  = 2 * SD_INIT_DIV * CLK_NS;
    localparam int FAST_SD_NS  = 2 * SD_FAST_DIV * CLK_NS;
    localparam int INIT_NS     = 1500 * SLOW_SD_NS;   // power-up clocks and nine commands
    localparam int SECTOR_NS   = 4400 * FAST_SD_NS;   // cmd17, block, crc and gap
    // each row loads three sectors and idles one more; two spare rows cover the restart
    localparam int WATCHDOG_NS = (NUM_ROWS + 2) * (INIT_NS + 4 * SECTOR_NS);

    typedef struct packed {
        bit         ccs;
        card_type_t exp_type;
        bit         mid_reset;
    } row_t;

    row_t rows [NUM_ROWS] = '{
        '{1'b1, CARD_SDHC, 1'b0},   // block addressing
        '{1'b0, CARD_SDV2, 1'b0},   // byte addressing
        '{1'b1, CARD_SDHC, 1'b1}    // reset partway through the image
    };

    logic       clk27mhz;
    logic       resetn;
    logic       ccs;
    wire        sdcmd;
    logic       sdcard_pwr_n;
    logic       sdclk;
    logic       sddat0;
    logic       sddat1;
    logic       sddat2;
    logic       sddat3;
    word_t      data;
    logic       we;
    logic       done;
    card_type_t card_type;
    card_stat_t card_stat;

    pullup (sdcmd);

    sd_loader UUT (
        .clk27mhz (clk27mhz), .resetn (resetn), .sdcard_pwr_n (sdcard_pwr_n),
        .sdclk (sdclk), .sdcmd (sdcmd), .sddat0 (sddat0), .sddat1 (sddat1),
        .sddat2 (sddat2), .sddat3 (sddat3), .data (data), .we (we), .done (done),
        .card_type (card_type), .card_stat (card_stat)
    );

    sd_card_model u_card (.sdclk (sdclk), .sdcmd (sdcmd), .sddat0 (sddat0), .ccs (ccs));

    initial clk27mhz = 1'b0;
    always #(CLK_NS / 2) clk27mhz = ~clk27mhz;

    // --------------------------------------------------
    // expected image and compare tasks
    // --------------------------------------------------
    function automatic byte_t pattern_byte(input int idx);
        int s;
        int i;
        s = idx / SECTOR_BYTES;
        i = idx % SECTOR_BYTES;
        return byte_t'(s * 37 + i * 5 + 11);
    endfunction

    function automatic word_t expected_word(input int k);
        return {pattern_byte(4*k + 3), pattern_byte(4*k + 2),
                pattern_byte(4*k + 1), pattern_byte(4*k)};   // little endian
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "run stopped at first mismatch");
        end
    endtask

    task automatic check_type(input card_type_t got, input card_type_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "run stopped at first mismatch");
        end
    endtask

    task automatic check_stat(input card_stat_t got, input card_stat_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "run stopped at first mismatch");
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "run stopped at first mismatch");
        end
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic apply_reset(input bit ccs_val);
        @(posedge clk27mhz);
        #1;
        resetn = 1'b0;
        ccs    = ccs_val;      // card type only changes under reset
        repeat (2) @(posedge clk27mhz);
        #1;
        resetn = 1'b1;
        @(negedge clk27mhz);
        check_flag(we, 1'b0, "we after reset");
        check_flag(done, 1'b0, "done after reset");
        check_flag(sdclk, 1'b0, "sdclk after reset");
        check_stat(card_stat, S_POWERUP, "card_stat after reset");
        check_flag(sdcard_pwr_n, 1'b0, "sdcard_pwr_n");
        check_flag(sddat1 && sddat2 && sddat3, 1'b1, "sddat1-3");
    endtask

    // collects words until stop_at of them are seen, sampled mid-cycle
    task automatic run_load(input int stop_at, input card_type_t exp_type);
        int words;
        words = 0;
        while (words < stop_at) begin
            @(negedge clk27mhz);
            check_flag(done, 1'b0, "done before last word");
            if (we) begin
                if (words == 0) begin
                    check_type(card_type, exp_type, "card_type at first word");
                    check_stat(card_stat, S_READ, "card_stat while reading");
                end
                check_word(data, expected_word(words), "loaded word");
                words++;
            end
        end
    endtask

    task automatic check_tail();
        bit seen_done;
        seen_done = 1'b0;
        repeat (SECTOR_NS / CLK_NS) begin   // rest of sector 2 must be dropped
            @(negedge clk27mhz);
            check_flag(we, 1'b0, "we after last word");
            if (seen_done)
                check_flag(done, 1'b1, "done held");
            seen_done = seen_done | done;
        end
        check_flag(done, 1'b1, "done after image");
        check_stat(card_stat, S_IDLE, "card_stat after image");   // no further sector asked for
    endtask

    initial begin
        int stop_word;
        void'($urandom(32'h73a4_73d6));
        resetn = 1'b0;
        ccs    = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_reset(rows[r].ccs);
            if (rows[r].mid_reset) begin
                stop_word = 10 + int'($urandom % 291);
                run_load(stop_word, rows[r].exp_type);
                apply_reset(rows[r].ccs);   // load starts over from sector 0
            end
            run_load(NUM_WORDS, rows[r].exp_type);
            check_tail();
        end
        $display("Testbench passed");
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: image not loaded within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- src.f
src/sd_loader_pkg.sv
src/sd_read_if.sv
src/sd_cmd_engine.sv
src/sd_data_rx.sv
src/sd_reader.sv
src/sd_loader.sv
sim/sd_card_model.sv
sim/tb_sd_loader.sv

//--- src/sd_cmd_engine.sv
`timescale 1ns/1ps

module sd_cmd_engine (
    input  logic                              clk27mhz,
    input  logic                              resetn,
    input  logic                              sd_tick_rise,
    input  logic                              sd_tick_fall,
    inout  wire                               sdcmd,
    input  logic                              cmd_start,
    input  sd_loader_pkg::cmd_idx_t           cmd_index,
    input  sd_loader_pkg::sd_arg_t            cmd_arg,
    input  logic                              resp_long,
    output logic                              cmd_busy,
    output logic                              resp_valid,
    output logic                              resp_timeout,
    output logic [sd_loader_pkg::RESP_W-1:0]  resp_bits
);
    import sd_loader_pkg::*;

    cmd_state_t        state;
    logic [39:0]       tx_sr;     // start, dir, index, argument
    logic [6:0]        crc;
    logic [5:0]        bit_cnt;   // tx bit, wait clocks or gap clocks
    logic [7:0]        rx_cnt;
    logic              long_q;
    logic              cmd_oe;
    logic              cmd_out;
    logic [RESP_W-1:0] resp_bits_q;

    // one step of x^7 + x^3 + 1
    function automatic logic [6:0] crc7_step(input logic [6:0] c, input logic din);
        logic fb;
        fb = din ^ c[6];
        crc7_step = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    endfunction

    assign sdcmd     = cmd_oe ? cmd_out : 1'bz;  // open line has a pull-up
    assign cmd_busy  = (state != C_IDLE);
    assign resp_bits = resp_bits_q;

    always_ff @(posedge clk27mhz) begin
        if (!resetn) begin
            state        <= C_IDLE;
            cmd_oe       <= 1'b0;
            cmd_out      <= 1'b1;
            bit_cnt      <= '0;
            rx_cnt       <= '0;
            resp_valid   <= 1'b0;
            resp_timeout <= 1'b0;
        end else begin
            resp_valid   <= 1'b0;
            resp_timeout <= 1'b0;
            case (state)
                C_IDLE: if (cmd_start) begin
                    tx_sr   <= {2'b01, cmd_index, cmd_arg};
                    crc     <= '0;
                    long_q  <= resp_long;
                    bit_cnt <= '0;
                    state   <= C_SEND;
                end
                // bits change on the falling edge, card samples on the rising one
                C_SEND: if (sd_tick_fall) begin
                    bit_cnt <= bit_cnt + 6'd1;
                    cmd_oe  <= 1'b1;
                    if (bit_cnt < 6'd40) begin
                        cmd_out <= tx_sr[39];
                        tx_sr   <= {tx_sr[38:0], 1'b0};
                        crc     <= crc7_step(crc, tx_sr[39]);
                    end else if (bit_cnt < 6'd47) begin
                        cmd_out <= crc[6];               // crc7 msb first
                        crc     <= {crc[5:0], 1'b0};
                    end else if (bit_cnt == 6'd47) begin
                        cmd_out <= 1'b1;                 // end bit
                    end else begin
                        cmd_oe  <= 1'b0;                 // hand the line to the card
                        bit_cnt <= '0;
                        state   <= C_WAIT;
                    end
                end
                C_WAIT: if (sd_tick_rise) begin
                    if (!sdcmd) begin
                        resp_bits_q <= {resp_bits_q[RESP_W-2:0], 1'b0};  // start bit
                        rx_cnt      <= 8'd1;
                        state       <= C_RECV;
                    end else if (bit_cnt == 6'd63) begin
                        resp_timeout <= 1'b1;            // 64 clocks, no answer
                        bit_cnt      <= '0;
                        state        <= C_GAP;
                    end else begin
                        bit_cnt <= bit_cnt + 6'd1;
                    end
                end
                C_RECV: if (sd_tick_rise) begin
                    resp_bits_q <= {resp_bits_q[RESP_W-2:0], sdcmd};
                    rx_cnt      <= rx_cnt + 8'd1;
                    if (rx_cnt == (long_q ? 8'd135 : 8'd47)) begin
                        resp_valid <= 1'b1;
                        bit_cnt    <= '0;
                        state      <= C_GAP;
                    end
                end
                // at least 8 clocks before the next command
                C_GAP: if (sd_tick_rise) begin
                    bit_cnt <= bit_cnt + 6'd1;
                    if (bit_cnt == 6'd7)
                        state <= C_IDLE;
                end
                default: state <= C_IDLE;
            endcase
        end
    end

endmodule

//--- src/sd_data_rx.sv
`timescale 1ns/1ps

module sd_data_rx (
    input  logic      clk27mhz,
    input  logic      resetn,
    input  logic      sd_tick_rise,
    input  logic      sddat0,
    input  logic      rx_arm,
    sd_read_if.reader rd,
    output logic      rx_done
);
    import sd_loader_pkg::*;

    logic                 in_data;   // inside the 4096 data bits
    logic                 in_tail;   // crc16 and end bit
    logic [BLK_CNT_W-1:0] cnt;
    byte_t                sh;

    always_ff @(posedge clk27mhz) begin
        if (!resetn || !rx_arm) begin
            in_data  <= 1'b0;
            in_tail  <= 1'b0;
            cnt      <= '0;
            rd.outen <= 1'b0;
            rx_done  <= 1'b0;
        end else begin
            rd.outen <= 1'b0;
            rx_done  <= 1'b0;
            if (sd_tick_rise) begin
                if (in_data) begin
                    sh  <= {sh[6:0], sddat0};   // msb first
                    cnt <= cnt + 1'b1;
                    if (cnt[2:0] == 3'd7) begin
                        rd.outbyte <= {sh[6:0], sddat0};
                        rd.outen   <= 1'b1;
                    end
                    if (cnt == '1) begin         // last of 4096 bits
                        in_data <= 1'b0;
                        in_tail <= 1'b1;
                        cnt     <= '0;
                    end
                end else if (in_tail) begin
                    cnt <= cnt + 1'b1;           // crc bits are not checked
                    if (cnt == BLK_CNT_W'(16)) begin
                        in_tail <= 1'b0;
                        rx_done <= 1'b1;
                    end
                end else if (!sddat0) begin
                    in_data <= 1'b1;             // start bit
                    cnt     <= '0;
                end
            end
        end
    end

    // bytes only while the reader expects a block
    a_outen_armed: assert property (@(posedge clk27mhz) disable iff (!resetn)
        rd.outen |-> rx_arm);

endmodule

//--- src/sd_loader.sv
`timescale 1ns/1ps

module sd_loader (
    input  logic                      clk27mhz,
    input  logic                      resetn,
    output logic                      sdcard_pwr_n,
    output logic                      sdclk,
    inout  wire                       sdcmd,
    input  logic                      sddat0,
    output logic                      sddat1,
    output logic                      sddat2,
    output logic                      sddat3,
    output sd_loader_pkg::word_t      data,
    output logic                      we,
    output logic                      done,
    output sd_loader_pkg::card_type_t card_type,
    output sd_loader_pkg::card_stat_t card_stat
);
    import sd_loader_pkg::*;

    sd_read_if rd_bus ();

    logic [LOAD_CNT_W-1:0] byte_cnt;
    logic                  image_full;

    assign sdcard_pwr_n = 1'b0;                 // card powered
    assign {sddat1, sddat2, sddat3} = 3'b111;   // keep card out of SPI mode
    assign image_full   = (byte_cnt >= LOAD_CNT_W'(LOAD_BYTES));

    //--------------------------------------------------
    // byte packing and sector stepping
    //--------------------------------------------------
    always_ff @(posedge clk27mhz) begin
        if (!resetn) begin
            we             <= 1'b0;
            done           <= 1'b0;
            byte_cnt       <= '0;
            rd_bus.rstart  <= 1'b1;
            rd_bus.rsector <= '0;
        end else begin
            we <= 1'b0;
            if (rd_bus.outen) begin
                if (!image_full) begin                          // late bytes are dropped
                    data     <= {rd_bus.outbyte, data[31:8]};   // little endian
                    we       <= (byte_cnt[1:0] == 2'd3);
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end else if (image_full) begin
                done          <= 1'b1;
                rd_bus.rstart <= 1'b0;
            end
            if (rd_bus.rdone)
                rd_bus.rsector <= rd_bus.rsector + 32'd1;       // ready before reader idles
        end
    end

    sd_reader u_reader (
        .clk27mhz  (clk27mhz),
        .resetn    (resetn),
        .rd        (rd_bus),
        .sdclk     (sdclk),
        .sdcmd     (sdcmd),
        .sddat0    (sddat0),
        .card_type (card_type),
        .card_stat (card_stat)
    );

    // once done, no word may follow
    a_no_we_after_done: assert property (@(posedge clk27mhz) disable iff (!resetn)
        !(we && done));

    // bytes only come while a sector read is in progress
    a_outen_busy: assert property (@(posedge clk27mhz) disable iff (!resetn)
        rd_bus.outen |-> rd_bus.rbusy);

endmodule

//--- src/sd_loader_pkg.sv
package sd_loader_pkg;

    // image and block geometry
    localparam int LOAD_BYTES   = 1280;   // two and a half sectors
    localparam int SECTOR_BYTES = 512;

    // sdclk half-period in clk27mhz cycles
    localparam int SD_INIT_DIV  = 34;     // ~400 kHz during identification
    localparam int SD_FAST_DIV  = 2;      // transfer mode

    // derived widths
    localparam int LOAD_CNT_W   = $clog2(LOAD_BYTES + 1);
    localparam int BLK_CNT_W    = $clog2(SECTOR_BYTES * 8);
    localparam int DIV_W        = $clog2(SD_INIT_DIV);
    localparam int RESP_W       = 136;    // longest response (R2)

    localparam int          POWERUP_CLKS = 80;            // >= 74 clocks before CMD0
    localparam logic [31:0] ACMD41_ARG   = 32'h40FF_8000; // HCS set, 2.7-3.6 V window

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [31:0] sector_t;
    typedef logic [31:0] sd_arg_t;
    typedef logic [5:0]  cmd_idx_t;
    typedef logic [1:0]  card_type_t;
    typedef logic [3:0]  card_stat_t;

    localparam card_type_t CARD_UNKNOWN = 2'd0;
    localparam card_type_t CARD_SDV2    = 2'd2;
    localparam card_type_t CARD_SDHC    = 2'd3;

    // numbering is visible outside as card_stat
    typedef enum logic [3:0] {
        S_POWERUP = 4'd0,
        S_CMD0    = 4'd1,
        S_CMD8    = 4'd2,
        S_CMD55   = 4'd3,
        S_ACMD41  = 4'd4,
        S_CMD2    = 4'd5,
        S_CMD3    = 4'd6,
        S_CMD7    = 4'd7,
        S_IDLE    = 4'd8,
        S_CMD17   = 4'd9,
        S_READ    = 4'd10,
        S_FAIL    = 4'd11
    } reader_state_t;

    typedef enum logic [2:0] {
        C_IDLE, C_SEND, C_WAIT, C_RECV, C_GAP
    } cmd_state_t;

endpackage

//--- src/sd_read_if.sv
`timescale 1ns/1ps

interface sd_read_if;
    import sd_loader_pkg::*;

    logic    rstart;   // level, read next sector while high
    sector_t rsector;  // held stable while rstart is high
    logic    rbusy;
    logic    rdone;    // pulse after last byte of a sector
    logic    outen;    // pulse, outbyte valid with it
    byte_t   outbyte;

    modport loader (
        output rstart, rsector,
        input  rbusy, rdone, outen, outbyte
    );

    modport reader (
        input  rstart, rsector,
        output rbusy, rdone, outen, outbyte
    );

endinterface

//--- src/sd_reader.sv
`timescale 1ns/1ps

module sd_reader (
    input  logic                      clk27mhz,
    input  logic                      resetn,
    sd_read_if.reader                 rd,
    output logic                      sdclk,
    inout  wire                       sdcmd,
    input  logic                      sddat0,
    output sd_loader_pkg::card_type_t card_type,
    output sd_loader_pkg::card_stat_t card_stat
);
    import sd_loader_pkg::*;

    reader_state_t     state;
    logic [DIV_W-1:0]  div_cnt;
    logic [DIV_W-1:0]  div_lim;
    logic              div_wrap;
    logic              fast_clk;
    logic              sd_tick_rise;
    logic              sd_tick_fall;
    logic              cmd_start;
    logic              cmd_busy;
    logic              resp_long;
    logic              resp_valid;
    logic              resp_timeout;
    cmd_idx_t          cmd_index;
    sd_arg_t           cmd_arg;
    logic [RESP_W-1:0] resp_bits;
    logic              issued;    // command of this state is out
    logic              is_cmd;
    logic              rx_arm;
    logic              rx_done;
    logic [15:0]       rca;
    logic [6:0]        pwr_cnt;

    //--------------------------------------------------
    // sdclk divider
    //--------------------------------------------------
    assign div_lim      = fast_clk ? DIV_W'(SD_FAST_DIV - 1) : DIV_W'(SD_INIT_DIV - 1);
    assign div_wrap     = (div_cnt >= div_lim);   // >= covers the speed switch
    assign sd_tick_rise = div_wrap && !sdclk;
    assign sd_tick_fall = div_wrap && sdclk;

    always_ff @(posedge clk27mhz) begin
        if (!resetn) begin
            div_cnt <= '0;
            sdclk   <= 1'b0;
        end else if (div_wrap) begin
            div_cnt <= '0;
            sdclk   <= !sdclk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    //--------------------------------------------------
    // command per state
    //--------------------------------------------------
    assign is_cmd = state inside {S_CMD0, S_CMD8, S_CMD55, S_ACMD41, S_CMD2,
                                  S_CMD3, S_CMD7, S_CMD17};

    always_comb begin
        cmd_index = 6'd0;   // CMD0, go idle
        cmd_arg   = '0;
        resp_long = 1'b0;
        case (state)
            S_CMD8:   begin cmd_index = 6'd8;  cmd_arg = 32'h0000_01AA; end  // 2.7-3.6 V, 0xaa
            S_CMD55:  begin cmd_index = 6'd55; cmd_arg = {rca, 16'h0000}; end
            S_ACMD41: begin cmd_index = 6'd41; cmd_arg = ACMD41_ARG; end
            S_CMD2:   begin cmd_index = 6'd2;  resp_long = 1'b1; end          // cid, R2
            S_CMD3:   cmd_index = 6'd3;
            S_CMD7:   begin cmd_index = 6'd7;  cmd_arg = {rca, 16'h0000}; end
            S_CMD17: begin
                cmd_index = 6'd17;
                // block address on SDHC, byte address on SDv2
                cmd_arg   = (card_type == CARD_SDHC) ? rd.rsector : {rd.rsector[22:0], 9'd0};
            end
            default: ;
        endcase
    end

    //--------------------------------------------------
    // init and read sequencer
    //--------------------------------------------------
    always_ff @(posedge clk27mhz) begin
        if (!resetn) begin
            state     <= S_POWERUP;
            issued    <= 1'b0;
            cmd_start <= 1'b0;
            fast_clk  <= 1'b0;
            card_type <= CARD_UNKNOWN;
            rca       <= '0;
            pwr_cnt   <= '0;
            rx_arm    <= 1'b0;
            rd.rdone  <= 1'b0;
        end else begin
            cmd_start <= 1'b0;
            rd.rdone  <= 1'b0;
            if (is_cmd && !issued && !cmd_busy) begin
                cmd_start <= 1'b1;
                issued    <= 1'b1;
                if (state == S_CMD17)
                    rx_arm <= 1'b1;   // data may follow the response closely
            end
            if (resp_valid || resp_timeout)
                issued <= 1'b0;
            case (state)
                S_POWERUP: if (sd_tick_rise) begin
                    pwr_cnt <= pwr_cnt + 7'd1;
                    if (pwr_cnt == 7'(POWERUP_CLKS - 1))
                        state <= S_CMD0;
                end
                S_CMD0: if (resp_valid || resp_timeout) state <= S_CMD8;  // no response
                S_CMD8: if (resp_valid)
                    state <= (resp_bits[15:8] == 8'hAA) ? S_CMD55 : S_FAIL;
                S_CMD55: if (resp_valid) state <= S_ACMD41;
                S_ACMD41: if (resp_valid) begin
                    if (resp_bits[39]) begin                 // ocr power-up done
                        card_type <= resp_bits[38] ? CARD_SDHC : CARD_SDV2;  // ccs
                        state     <= S_CMD2;
                    end else begin
                        state <= S_CMD55;                    // still busy, ask again
                    end
                end
                S_CMD2: if (resp_valid) state <= S_CMD3;
                S_CMD3: if (resp_valid) begin
                    rca   <= resp_bits[39:24];               // published rca, R6
                    state <= S_CMD7;
                end
                S_CMD7: if (resp_valid) begin
                    fast_clk <= 1'b1;                        // card is in transfer state
                    state    <= S_IDLE;
                end
                S_IDLE:  if (rd.rstart) state <= S_CMD17;
                S_CMD17: if (resp_valid) state <= S_READ;
                S_READ: if (rx_done) begin
                    rx_arm   <= 1'b0;
                    rd.rdone <= 1'b1;
                    state    <= S_IDLE;
                end
                default: ;                                   // S_FAIL holds
            endcase
            if (resp_timeout && state != S_CMD0) begin
                rx_arm <= 1'b0;
                state  <= S_FAIL;
            end
        end
    end

    assign rd.rbusy  = (state == S_CMD17) || (state == S_READ);
    assign card_stat = card_stat_t'(state);

    sd_cmd_engine u_cmd (
        .clk27mhz     (clk27mhz),
        .resetn       (resetn),
        .sd_tick_rise (sd_tick_rise),
        .sd_tick_fall (sd_tick_fall),
        .sdcmd        (sdcmd),
        .cmd_start    (cmd_start),
        .cmd_index    (cmd_index),
        .cmd_arg      (cmd_arg),
        .resp_long    (resp_long),
        .cmd_busy     (cmd_busy),
        .resp_valid   (resp_valid),
        .resp_timeout (resp_timeout),
        .resp_bits    (resp_bits)
    );

    sd_data_rx u_rx (
        .clk27mhz     (clk27mhz),
        .resetn       (resetn),
        .sd_tick_rise (sd_tick_rise),
        .sddat0       (sddat0),
        .rx_arm       (rx_arm),
        .rd           (rd),
        .rx_done      (rx_done)
    );

    // the engine takes a new command only when idle
    a_start_idle: assert property (@(posedge clk27mhz) disable iff (!resetn)
        cmd_start |-> !cmd_busy);

endmodule
